// File: flist.f
common/bridge_pkg.sv
fifo_async/gray_ptr_sync.sv
fifo_async/fifo_async.sv
verilog/byte_packer.sv
verilog/byte_unpacker.sv
verilog/stream_bridge_top.sv
sim/bridge_checker.sv
sim/tb_stream_bridge.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile with verilator, run, and look for the pass message in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
    -f flist.f --top-module tb_stream_bridge -o tb_stream_bridge \
    && ./obj_dir/tb_stream_bridge | tee /dev/stderr | grep -F "Everything OK" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: sim/tb_stream_bridge.sv
module tb_stream_bridge
    import bridge_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [1:0] HOLD_NONE = 2'd0;
    localparam logic [1:0] HOLD_RAND = 2'd1;
    localparam logic [1:0] HOLD_LONG = 2'd2;
    localparam int NUM_ROWS = 11;
    localparam int LONG_HOLD_CYCLES = 60;

    // one table row per test
    typedef struct packed {
        logic [7:0] len;
        logic [7:0] npkts;
        logic [1:0] hold;
    } row_t;

    logic  wr_clk;
    logic  wr_rst;
    logic  wr_byte_valid;
    byte_t wr_byte;
    logic  wr_stall;
    logic  rd_clk;
    logic  rd_rst;
    logic  rd_hold;
    logic  rd_byte_valid;
    byte_t rd_byte;

    int in_count;
    int out_count;
    int err_count;
    int stall_rises;

    row_t       rows [NUM_ROWS];
    logic [1:0] hold_mode;
    int         long_left;
    integer     seed = 32'h7540_0da6;
    logic [7:0] next_val;
    int         tb_errors;
    int         pass_count;
    int         fail_count;
    int         limit_cycles;
    int         cycles;

    stream_bridge_top UUT (
        .wr_clk        (wr_clk),
        .wr_rst        (wr_rst),
        .wr_byte_valid (wr_byte_valid),
        .wr_byte       (wr_byte),
        .wr_stall      (wr_stall),
        .rd_clk        (rd_clk),
        .rd_rst        (rd_rst),
        .rd_hold       (rd_hold),
        .rd_byte_valid (rd_byte_valid),
        .rd_byte       (rd_byte)
    );

    bridge_checker u_check (
        .wr_clk        (wr_clk),
        .wr_rst        (wr_rst),
        .wr_byte_valid (wr_byte_valid),
        .wr_byte       (wr_byte),
        .wr_stall      (wr_stall),
        .rd_clk        (rd_clk),
        .rd_rst        (rd_rst),
        .rd_hold       (rd_hold),
        .rd_byte_valid (rd_byte_valid),
        .rd_byte       (rd_byte),
        .in_count      (in_count),
        .out_count     (out_count),
        .err_count     (err_count),
        .stall_rises   (stall_rises)
    );

    initial begin
        wr_clk = 1'b0;
        forever #2 wr_clk = ~wr_clk;
    end

    // half-ns offset keeps rd edges and drive times clear of wr edges
    initial begin
        rd_clk = 1'b0;
        #0.5;
        forever #3 rd_clk = ~rd_clk;
    end

    initial begin
        rd_rst = 1'b1;
        repeat (3) @(posedge rd_clk);
        #1;
        rd_rst = 1'b0;
    end

    // hold level for the read side, follows the current row's pattern
    initial begin
        rd_hold = 1'b0;
        forever begin
            @(posedge rd_clk);
            #1;
            if (hold_mode == HOLD_RAND) begin
                rd_hold = (($random(seed) & 3) == 0);
            end else if (hold_mode == HOLD_LONG && long_left > 0) begin
                rd_hold = 1'b1;
                long_left = long_left - 1;
            end else begin
                rd_hold = 1'b0;
            end
        end
    end

    initial begin
        cycles = 0;
        wait (limit_cycles != 0);
        while (cycles < limit_cycles) begin
            @(posedge rd_clk);
            cycles = cycles + 1;
        end
        $display("timeout: the tests did not finish within %0d rd_clk cycles", limit_cycles);
        $display("Something failed");
        $finish;
    end

    task automatic load_table();
        rows[0]  = '{8'd4,  8'd8,  HOLD_NONE};
        rows[1]  = '{8'd8,  8'd4,  HOLD_NONE};
        rows[2]  = '{8'd1,  8'd5,  HOLD_NONE};
        rows[3]  = '{8'd2,  8'd5,  HOLD_NONE};
        rows[4]  = '{8'd3,  8'd5,  HOLD_NONE};
        rows[5]  = '{8'd5,  8'd4,  HOLD_NONE};
        rows[6]  = '{8'd13, 8'd3,  HOLD_NONE};
        rows[7]  = '{8'd7,  8'd6,  HOLD_RAND};
        rows[8]  = '{8'd12, 8'd4,  HOLD_RAND};
        rows[9]  = '{8'd4,  8'd16, HOLD_LONG};
        rows[10] = '{8'd13, 8'd2,  HOLD_RAND};
    endtask

    function automatic int compute_limit();
        int total;
        int longs;
        total = 0;
        longs = 0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            total = total + int'(rows[i].len) * int'(rows[i].npkts);
            if (rows[i].hold == HOLD_LONG) begin
                longs = longs + 1;
            end
        end
        return 40 * total + 200 + LONG_HOLD_CYCLES * longs;
    endfunction

    function automatic string hold_name(input logic [1:0] hold);
        case (hold)
            HOLD_RAND: return "random";
            HOLD_LONG: return "long";
            default:   return "none";
        endcase
    endfunction

    task automatic finish_test(input string label, input int errs_before);
        if (err_count + tb_errors == errs_before) begin
            pass_count = pass_count + 1;
            $display("%s: pass", label);
        end else begin
            fail_count = fail_count + 1;
            $display("%s: FAIL", label);
        end
    endtask

    // called 1 ns after a wr_clk edge, returns 1 ns after the accepting edge
    task automatic send_byte(input byte_t b);
        while (wr_stall) begin
            @(posedge wr_clk);
            #1;
        end
        wr_byte_valid = 1'b1;
        wr_byte = b;
        @(posedge wr_clk);
        #1;
        wr_byte_valid = 1'b0;
    endtask

    task automatic send_packet(input int len);
        byte_t b;
        for (int j = 0; j < len; j++) begin
            b.data = next_val;
            b.last = (j == len - 1);
            next_val = next_val + 8'd1;
            send_byte(b);
        end
    endtask

    task automatic wait_stall_low(input string label);
        int n;
        n = 0;
        while (wr_stall && n < 10) begin
            @(posedge wr_clk);
            #1;
            n = n + 1;
        end
        if (wr_stall) begin
            tb_errors = tb_errors + 1;
            $display("%s: wr_stall is still high 10 cycles later", label);
        end
    endtask

    task automatic check_reset();
        int errs_before;
        errs_before = err_count + tb_errors;
        repeat (2) @(posedge wr_clk);
        #1;
        if (wr_stall !== 1'b1) begin
            tb_errors = tb_errors + 1;
            $display("reset: wr_stall is not high while wr_rst is asserted");
        end
        @(posedge wr_clk);
        #1;
        wr_rst = 1'b0;
        wait (rd_rst == 1'b0);
        @(posedge wr_clk);
        #1;
        wait_stall_low("reset");
        if (rd_byte_valid !== 1'b0) begin
            tb_errors = tb_errors + 1;
            $display("reset: rd_byte_valid is not low after reset");
        end
        finish_test("reset check", errs_before);
    endtask

    task automatic run_row(input int i);
        row_t r;
        int errs_before;
        int rises_before;
        r = rows[i];
        errs_before = err_count + tb_errors;
        rises_before = stall_rises;
        @(posedge wr_clk);
        #1;
        if (r.hold == HOLD_LONG) begin
            long_left = LONG_HOLD_CYCLES;
        end
        hold_mode = r.hold;
        for (int p = 0; p < int'(r.npkts); p++) begin
            send_packet(int'(r.len));
        end
        while (out_count != in_count) begin
            @(posedge rd_clk);
        end
        hold_mode = HOLD_NONE;
        if (r.hold == HOLD_LONG) begin
            if (stall_rises == rises_before) begin
                tb_errors = tb_errors + 1;
                $display("test %0d: wr_stall never rose during the long hold", i);
            end
            @(posedge wr_clk);
            #1;
            wait_stall_low($sformatf("test %0d", i));
        end
        finish_test($sformatf("test %0d: %0d packets of %0d bytes, hold %s",
                              i, r.npkts, r.len, hold_name(r.hold)), errs_before);
    endtask

    initial begin
        wr_rst = 1'b1;
        wr_byte_valid = 1'b0;
        wr_byte = '0;
        hold_mode = HOLD_NONE;
        long_left = 0;
        next_val = 8'd0;
        tb_errors = 0;
        pass_count = 0;
        fail_count = 0;
        limit_cycles = 0;
        load_table();
        limit_cycles = compute_limit();
        check_reset();
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end
        $display("tests passed %0d, failed %0d, check errors %0d",
                 pass_count, fail_count, err_count + tb_errors);
        if (fail_count == 0 && err_count == 0 && tb_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: sim/bridge_checker.sv
module bridge_checker
    import bridge_pkg::*;
(
    input  logic  wr_clk,
    input  logic  wr_rst,
    input  logic  wr_byte_valid,
    input  byte_t wr_byte,
    input  logic  wr_stall,
    input  logic  rd_clk,
    input  logic  rd_rst,
    input  logic  rd_hold,
    input  logic  rd_byte_valid,
    input  byte_t rd_byte,
    output int    in_count,
    output int    out_count,
    output int    err_count,
    output int    stall_rises
);

    timeunit 1ns;
    timeprecision 100ps;

    byte_t exp_q [$];
    byte_t exp_byte;
    logic  accept;
    logic  beat_end;
    logic  stall_d;
    int    lane;
    int    hold_beats;
    int    wr_errs;
    int    rd_errs;

    // a byte counts once the source strobes it with stall low
    assign accept    = wr_byte_valid && !wr_stall;
    assign beat_end  = accept && (wr_byte.last || lane == BEAT_BYTES - 1);
    assign err_count = wr_errs + rd_errs;

    initial begin
        in_count = 0;
        out_count = 0;
        stall_rises = 0;
        wr_errs = 0;
        rd_errs = 0;
    end

    always @(posedge wr_clk) begin
        if (wr_rst) begin
            lane <= 0;
            hold_beats <= 0;
            stall_d <= 1'b1;
        end else begin
            stall_d <= wr_stall;
            if (wr_stall && !stall_d) begin
                stall_rises <= stall_rises + 1;
            end
            if (accept) begin
                exp_q.push_back(wr_byte);
                in_count <= in_count + 1;
                lane <= beat_end ? 0 : lane + 1;
            end
            // beats taken in while the read side is held
            if (!rd_hold) begin
                hold_beats <= 0;
            end else if (beat_end) begin
                hold_beats <= hold_beats + 1;
                // room for a full fifo and the beat an idle unpacker still pops
                if (hold_beats == 2 ** FIFO_ADDR) begin
                    wr_errs <= wr_errs + 1;
                    $display("at %0.1f ns: %0d beats accepted during one hold without wr_stall",
                             $realtime, hold_beats + 1);
                end
            end
        end
    end

    always @(posedge rd_clk) begin
        if (!rd_rst) begin
            if (rd_byte_valid && rd_hold) begin
                rd_errs <= rd_errs + 1;
                $display("CHECK FAILED at %0.1f ns: rd_byte_valid high while rd_hold is high",
                         $realtime);
            end
            if (rd_byte_valid) begin
                out_count <= out_count + 1;
                if (exp_q.size() == 0) begin
                    rd_errs <= rd_errs + 1;
                    $display("at %0.1f ns: output byte %02h arrived with no input byte pending",
                             $realtime, rd_byte.data);
                end else begin
                    exp_byte = exp_q.pop_front();
                    if (rd_byte !== exp_byte) begin
                        rd_errs <= rd_errs + 1;
                        $display("CHECK FAILED at %0.1f ns: got %02h last %0b, want %02h last %0b",
                                 $realtime, rd_byte.data, rd_byte.last,
                                 exp_byte.data, exp_byte.last);
                    end
                end
            end
        end
    end

endmodule

// File: verilog/stream_bridge_top.sv
module stream_bridge_top
    import bridge_pkg::*;
(
    input  logic  wr_clk,
    input  logic  wr_rst,
    input  logic  wr_byte_valid,
    input  byte_t wr_byte,
    output logic  wr_stall,

    input  logic  rd_clk,
    input  logic  rd_rst,
    input  logic  rd_hold,
    output logic  rd_byte_valid,
    output byte_t rd_byte
);

    logic  push;
    beat_t beat_in;
    beat_t rd_beat;
    logic  rd_empty;
    logic  pop;

    byte_packer u_packer (
        .wr_clk        (wr_clk),
        .wr_rst        (wr_rst),
        .wr_byte_valid (wr_byte_valid),
        .wr_byte       (wr_byte),
        .wr_stall      (wr_stall),
        .push          (push),
        .beat_in       (beat_in)
    );

    // almost-full doubles as the source stall
    fifo_async #(
        .ADDR           (FIFO_ADDR),
        .ALMOST_FULL    (FIFO_ALMOST_FULL)
    ) u_fifo (
        .wr_clk         (wr_clk),
        .wr_rst         (wr_rst),
        .push           (push),
        .beat_in        (beat_in),
        .wr_full        (),
        .wr_almost_full (wr_stall),
        .wr_free        (),
        .rd_clk         (rd_clk),
        .rd_rst         (rd_rst),
        .pop            (pop),
        .rd_beat        (rd_beat),
        .rd_empty       (rd_empty),
        .rd_count       ()
    );

    byte_unpacker u_unpacker (
        .rd_clk        (rd_clk),
        .rd_rst        (rd_rst),
        .rd_hold       (rd_hold),
        .rd_beat       (rd_beat),
        .rd_empty      (rd_empty),
        .pop           (pop),
        .rd_byte_valid (rd_byte_valid),
        .rd_byte       (rd_byte)
    );

endmodule

// File: verilog/byte_unpacker.sv
module byte_unpacker
    import bridge_pkg::*;
(
    input  logic  rd_clk,
    input  logic  rd_rst,
    input  logic  rd_hold,
    input  beat_t rd_beat,
    input  logic  rd_empty,
    output logic  pop,
    output logic  rd_byte_valid,
    output byte_t rd_byte
);

    beat_t                 cur;
    logic                  busy;
    logic [BEAT_IDX_W-1:0] idx;
    logic                  send;
    logic                  final_byte;

    assign send       = busy && !rd_hold;
    assign final_byte = (idx == cur.nbytes_m1);

    // refill when idle or while the last byte of the beat goes out
    assign pop = !rd_empty && (!busy || (send && final_byte));

    assign rd_byte_valid = send;

    always_comb begin
        rd_byte.data = cur.data[idx*8 +: 8];
        // packet end only on the final byte of a last beat
        rd_byte.last = cur.last && final_byte;
    end

    always_ff @(posedge rd_clk) begin
        if (rd_rst) begin
            busy <= 1'b0;
            idx  <= '0;
        end else if (pop) begin
            busy <= 1'b1;
            idx  <= '0;
        end else if (send) begin
            if (final_byte) begin
                busy <= 1'b0;
            end else begin
                idx <= idx + 1'b1;
            end
        end
    end

    always_ff @(posedge rd_clk) begin
        if (pop) begin
            cur <= rd_beat;
        end
    end

    a_no_valid_on_hold: assert property (@(posedge rd_clk) disable iff (rd_rst)
        rd_hold |-> !rd_byte_valid)
        else $error("byte_unpacker: rd_byte_valid high during rd_hold");

    // a held byte is still there once the hold is over
    a_hold_keeps_byte: assert property (@(posedge rd_clk) disable iff (rd_rst)
        busy && rd_hold |=> busy && $stable(rd_byte))
        else $error("byte_unpacker: byte changed during rd_hold");

endmodule

// File: verilog/byte_packer.sv
module byte_packer
    import bridge_pkg::*;
(
    input  logic  wr_clk,
    input  logic  wr_rst,
    input  logic  wr_byte_valid,
    input  byte_t wr_byte,
    input  logic  wr_stall,
    output logic  push,
    output beat_t beat_in
);

    logic [BEAT_IDX_W-1:0]   idx;
    logic [BEAT_BYTES*8-1:0] lanes;
    logic [BEAT_BYTES*8-1:0] lanes_next;
    logic                    accept;
    logic                    beat_done;

    // a strobe during stall is a source error and is ignored
    assign accept    = wr_byte_valid && !wr_stall;
    assign beat_done = accept && (wr_byte.last || idx == BEAT_IDX_W'(BEAT_BYTES - 1));

    // drop the incoming byte into its lane
    always_comb begin
        lanes_next = lanes;
        lanes_next[idx*8 +: 8] = wr_byte.data;
    end

    always_ff @(posedge wr_clk) begin
        if (wr_rst) begin
            idx  <= '0;
            push <= 1'b0;
        end else begin
            push <= beat_done;
            if (beat_done) begin
                idx <= '0;
            end else if (accept) begin
                idx <= idx + 1'b1;
            end
        end
    end

    // lanes above idx may hold stale bytes, nbytes_m1 masks them
    always_ff @(posedge wr_clk) begin
        if (accept) begin
            lanes <= lanes_next;
        end
    end

    // finished beat, presented with push one cycle after its final byte
    always_ff @(posedge wr_clk) begin
        if (beat_done) begin
            beat_in.data      <= lanes_next;
            beat_in.nbytes_m1 <= idx;
            beat_in.last      <= wr_byte.last;
        end
    end

    // source must watch the fifo almost-full level
    a_no_strobe_on_stall: assert property (@(posedge wr_clk) disable iff (wr_rst)
        !(wr_byte_valid && wr_stall))
        else $error("byte_packer: byte strobe while wr_stall is high");

endmodule

// File: fifo_async/fifo_async.sv
module fifo_async
    import bridge_pkg::*;
#(
    parameter int ADDR        = FIFO_ADDR,
    parameter int ALMOST_FULL = FIFO_ALMOST_FULL
) (
    input  logic          wr_clk,
    input  logic          wr_rst,
    input  logic          push,
    input  beat_t         beat_in,
    output logic          wr_full,
    output logic          wr_almost_full,
    output logic [ADDR:0] wr_free,

    input  logic          rd_clk,
    input  logic          rd_rst,
    input  logic          pop,
    output beat_t         rd_beat,
    output logic          rd_empty,
    output logic [ADDR:0] rd_count
);

    localparam int DEPTH = 2 ** ADDR;
    localparam int PTR_W = ADDR + 1;
    localparam logic [ADDR:0] MSB = {1'b1, {ADDR{1'b0}}};

    beat_t mem [DEPTH];

    // write domain
    logic [ADDR:0]   wr_ptr;
    logic [ADDR:0]   wr_ptr_p1;
    logic [ADDR:0]   wr_ptr_next;
    logic [ADDR:0]   wr_ptr_p1_next;
    logic [ADDR:0]   wr_rd_bin;
    logic [ADDR:0]   wr_rd_ptr;
    logic [ADDR:0]   wr_free_next;
    logic            wr_full_next;
    logic [ADDR:0]   wr_af;
    logic [ADDR:0]   wr_af_p1;
    logic [ADDR:0]   wr_af_next;
    logic [ADDR:0]   wr_af_p1_next;
    logic [ADDR:0]   wr_af_free;
    logic [ADDR-1:0] wr_addr_r;
    logic            wr_push_r;
    beat_t           wr_data_r;

    // read domain
    logic [ADDR:0]   rd_ptr;
    logic [ADDR:0]   rd_ptr_p1;
    logic [ADDR:0]   rd_ptr_next;
    logic [ADDR:0]   rd_ptr_p1_next;
    logic [ADDR:0]   rd_wr_ptr;
    logic [ADDR:0]   rd_count_next;
    logic            rd_empty_next;

    // read pointer with top bit flipped, so equality means full
    assign wr_rd_ptr = wr_rd_bin ^ MSB;

    assign wr_ptr_p1_next = push ? wr_ptr_p1 + 1'b1 : wr_ptr_p1;
    assign wr_ptr_next    = push ? wr_ptr_p1 : wr_ptr;
    assign wr_free_next   = wr_rd_ptr - wr_ptr_next;
    assign wr_full_next   = (wr_rd_ptr == wr_ptr_next);

    // shadow pointer running ALMOST_FULL+1 ahead of the write pointer
    assign wr_af_p1_next = push ? wr_af_p1 + 1'b1 : wr_af_p1;
    assign wr_af_next    = push ? wr_af_p1 : wr_af;
    assign wr_af_free    = wr_rd_ptr - wr_af_next;

    always_ff @(posedge wr_clk) begin
        if (wr_rst) begin
            wr_ptr         <= '0;
            wr_ptr_p1      <= PTR_W'(1);
            wr_af          <= PTR_W'(ALMOST_FULL + 1);
            wr_af_p1       <= PTR_W'(ALMOST_FULL + 2);
            wr_free        <= '0;
            wr_full        <= 1'b1;
            wr_almost_full <= 1'b1;
        end else begin
            wr_ptr         <= wr_ptr_next;
            wr_ptr_p1      <= wr_ptr_p1_next;
            wr_af          <= wr_af_next;
            wr_af_p1       <= wr_af_p1_next;
            wr_free        <= wr_free_next;
            wr_full        <= wr_full_next;
            // negative headroom means almost full
            wr_almost_full <= wr_af_free[ADDR];
        end
    end

    // write strobe, address and data re-registered ahead of the memory
    always_ff @(posedge wr_clk) begin
        if (wr_rst) begin
            wr_push_r <= 1'b0;
        end else begin
            wr_push_r <= push;
        end
    end

    always_ff @(posedge wr_clk) begin
        wr_addr_r <= wr_ptr[ADDR-1:0];
        wr_data_r <= beat_in;
    end

    always_ff @(posedge wr_clk) begin
        if (wr_push_r) begin
            mem[wr_addr_r] <= wr_data_r;
        end
    end

    assign rd_ptr_p1_next = pop ? rd_ptr_p1 + 1'b1 : rd_ptr_p1;
    assign rd_ptr_next    = pop ? rd_ptr_p1 : rd_ptr;
    assign rd_count_next  = rd_wr_ptr - rd_ptr_next;
    assign rd_empty_next  = (rd_wr_ptr == rd_ptr_next);

    always_ff @(posedge rd_clk) begin
        if (rd_rst) begin
            rd_ptr    <= '0;
            rd_ptr_p1 <= PTR_W'(1);
            rd_count  <= '0;
            rd_empty  <= 1'b1;
        end else begin
            rd_ptr    <= rd_ptr_next;
            rd_ptr_p1 <= rd_ptr_p1_next;
            rd_count  <= rd_count_next;
            rd_empty  <= rd_empty_next;
        end
    end

    assign rd_beat = mem[rd_ptr[ADDR-1:0]];

    // wr_ptr lags push by a cycle, which lines it up with the memory write
    gray_ptr_sync #(
        .WIDTH   (PTR_W)
    ) u_wr_ptr_sync (
        .src_clk (wr_clk),
        .src_rst (wr_rst),
        .src_bin (wr_ptr),
        .dst_clk (rd_clk),
        .dst_rst (rd_rst),
        .dst_bin (rd_wr_ptr)
    );

    gray_ptr_sync #(
        .WIDTH   (PTR_W)
    ) u_rd_ptr_sync (
        .src_clk (rd_clk),
        .src_rst (rd_rst),
        .src_bin (rd_ptr_next),
        .dst_clk (wr_clk),
        .dst_rst (wr_rst),
        .dst_bin (wr_rd_bin)
    );

    a_overflow: assert property (@(posedge wr_clk) disable iff (wr_rst)
        !(push && wr_full))
        else $error("fifo_async: push while full");

    a_underflow: assert property (@(posedge rd_clk) disable iff (rd_rst)
        !(pop && rd_empty))
        else $error("fifo_async: pop while empty");

endmodule

// File: fifo_async/gray_ptr_sync.sv
module gray_ptr_sync #(
    parameter int WIDTH = 4
) (
    input  logic             src_clk,
    input  logic             src_rst,
    input  logic [WIDTH-1:0] src_bin,

    input  logic             dst_clk,
    input  logic             dst_rst,
    output logic [WIDTH-1:0] dst_bin
);

    logic [WIDTH-1:0] src_gray;
    logic [WIDTH-1:0] dst_meta;
    logic [WIDTH-1:0] dst_gray;

    // gray register in the source domain, only one bit moves per step
    always_ff @(posedge src_clk) begin
        if (src_rst) begin
            src_gray <= '0;
        end else begin
            src_gray <= src_bin ^ (src_bin >> 1);
        end
    end

    // two-flop synchronizer
    always_ff @(posedge dst_clk) begin
        if (dst_rst) begin
            dst_meta <= '0;
            dst_gray <= '0;
        end else begin
            dst_meta <= src_gray;
            dst_gray <= dst_meta;
        end
    end

    // back to binary, bit i is the xor of all gray bits from i upward
    always_comb begin
        for (int i = 0; i < WIDTH; i++) begin
            dst_bin[i] = ^(dst_gray >> i);
        end
    end

endmodule

// File: common/bridge_pkg.sv
package bridge_pkg;

    // bytes per beat and the lane index width
    localparam int BEAT_BYTES = 4;
    localparam int BEAT_IDX_W = $clog2(BEAT_BYTES);

    // fifo depth is 2**FIFO_ADDR
    localparam int FIFO_ADDR = 3;

    // one spare slot for a beat the packer may still push after stall rises
    localparam int FIFO_ALMOST_FULL = 1;

    // single byte on the stream ports
    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } byte_t;

    // beat carried through the fifo
    // byte 0 sits in data[7:0]
    typedef struct packed {
        logic [BEAT_BYTES*8-1:0] data;
        logic [BEAT_IDX_W-1:0]   nbytes_m1;
        logic                    last;
    } beat_t;

endpackage
